/* rtl/dma_cfg_pkg.sv */
package dma_cfg_pkg;

  // Width of one data beat
  localparam int DATA_WIDTH = 32;

  // In-burst beat counter for 16-beat bursts
  localparam int BEATS_PER_BURST_WIDTH = 4;

  // Burst ids wrap modulo 8
  localparam int ID_WIDTH = 3;

  // Half the id range so a full buffer and an empty one differ
  localparam int NUM_SLOTS = 4;

  // Transfer length holds beats minus one
  localparam int LEN_WIDTH = 8;

endpackage

/* rtl/dma_ctrl_pkg.sv */
package dma_ctrl_pkg;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } ctrl_state_e;

  function automatic logic [dma_cfg_pkg::ID_WIDTH-1:0] id_next(
    input logic [dma_cfg_pkg::ID_WIDTH-1:0] id
  );
    return id + 1'b1;
  endfunction

  // Top id bit only tells apart two passes over the same slot
  function automatic logic [dma_cfg_pkg::ID_WIDTH-2:0] id_slot(
    input logic [dma_cfg_pkg::ID_WIDTH-1:0] id
  );
    return id[dma_cfg_pkg::ID_WIDTH-2:0];
  endfunction

  function automatic logic [dma_cfg_pkg::ID_WIDTH-1:0] ids_in_use(
    input logic [dma_cfg_pkg::ID_WIDTH-1:0] head,
    input logic [dma_cfg_pkg::ID_WIDTH-1:0] tail
  );
    return head - tail; // Modulo distance
  endfunction

endpackage

/* rtl/dma_request_ctrl.sv */
`timescale 1ns/1ps

module dma_request_ctrl (
  input  logic                                          clk,
  input  logic                                          resetn,
  input  logic                                          xfer_start,
  input  logic [dma_cfg_pkg::LEN_WIDTH-1:0]             xfer_beats,
  input  logic                                          xfer_sync,
  output logic                                          xfer_busy,
  output logic                                          xfer_done,
  output logic                                          req_valid,
  input  logic                                          req_ready,
  output logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] req_last_burst_length,
  output logic                                          req_sync_transfer_start,
  output logic [dma_cfg_pkg::ID_WIDTH-1:0]              request_id,
  input  logic [dma_cfg_pkg::ID_WIDTH-1:0]              response_id,
  output logic                                          eot,
  input  logic [dma_cfg_pkg::ID_WIDTH-1:0]              dest_id
);

  dma_ctrl_pkg::ctrl_state_e state;

  // One bit wider than the burst index to hold a count of 16
  logic [dma_cfg_pkg::LEN_WIDTH-dma_cfg_pkg::BEATS_PER_BURST_WIDTH:0] bursts_left;
  logic [dma_cfg_pkg::ID_WIDTH-1:0] final_id;
  logic final_granted;
  logic grant;

  assign xfer_busy = state != dma_ctrl_pkg::IDLE;
  assign req_valid = state == dma_ctrl_pkg::ISSUE;

  assign grant = (bursts_left != '0) &&
                 (dma_ctrl_pkg::ids_in_use(request_id, dest_id) < dma_cfg_pkg::NUM_SLOTS);

  // Final burst is being filled
  assign eot = final_granted && (response_id == final_id);

  // All granted bursts drained once dest_id catches up
  assign xfer_done = (state == dma_ctrl_pkg::DRAIN) && final_granted &&
                     (dest_id == request_id);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= dma_ctrl_pkg::IDLE;
    end else begin
      case (state)
        dma_ctrl_pkg::IDLE: begin
          if (xfer_start) begin
            state <= dma_ctrl_pkg::ISSUE;
          end
        end
        dma_ctrl_pkg::ISSUE: begin
          if (req_ready) begin
            state <= dma_ctrl_pkg::DRAIN;
          end
        end
        dma_ctrl_pkg::DRAIN: begin
          if (xfer_done) begin
            state <= dma_ctrl_pkg::IDLE;
          end
        end
        default: state <= dma_ctrl_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bursts_left   <= '0;
      request_id    <= '0;
      final_granted <= 1'b0;
    end else begin
      if (state == dma_ctrl_pkg::IDLE && xfer_start) begin
        bursts_left <= {1'b0, xfer_beats[dma_cfg_pkg::LEN_WIDTH-1:
                                         dma_cfg_pkg::BEATS_PER_BURST_WIDTH]} + 1'b1;
        final_granted <= 1'b0;
      end
      if (grant) begin
        request_id  <= dma_ctrl_pkg::id_next(request_id);
        bursts_left <= bursts_left - 1'b1;
        if (bursts_left == 1) begin
          final_granted <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == dma_ctrl_pkg::IDLE && xfer_start) begin
      req_last_burst_length   <= xfer_beats[dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0];
      req_sync_transfer_start <= xfer_sync;
    end
    if (grant && bursts_left == 1) begin
      final_id <= request_id;
    end
  end

endmodule

/* rtl/dma_data_mover.sv */
`timescale 1ns/1ps

module dma_data_mover (
  input  logic                                          clk,
  input  logic                                          resetn,
  input  logic [dma_cfg_pkg::ID_WIDTH-1:0]              request_id,
  output logic [dma_cfg_pkg::ID_WIDTH-1:0]              response_id,
  input  logic                                          eot,
  input  logic                                          req_valid,
  output logic                                          req_ready,
  input  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] req_last_burst_length,
  input  logic                                          req_sync_transfer_start,
  input  logic                                          s_valid,
  output logic                                          s_ready,
  input  logic [dma_cfg_pkg::DATA_WIDTH-1:0]            s_data,
  input  logic                                          s_sync,
  output logic                                          wr_valid,
  output logic [dma_cfg_pkg::DATA_WIDTH-1:0]            wr_data,
  output logic [dma_cfg_pkg::ID_WIDTH-1:0]              wr_id,
  output logic                                          wr_last,
  output logic                                          bl_valid,
  output logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] measured_last_burst_length
);

  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] last_burst_length;
  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] beat_counter;
  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] beat_counter_minus_one;
  logic [dma_cfg_pkg::ID_WIDTH-1:0] id;
  logic [dma_cfg_pkg::ID_WIDTH-1:0] next_id;
  logic pending_burst;
  logic active;
  logic last_eot;
  logic last_non_eot;
  logic needs_sync;
  logic has_sync;
  logic last;
  logic last_load;

  assign has_sync = ~needs_sync | s_sync;
  assign s_ready  = pending_burst & active;
  assign wr_valid = s_valid & s_ready & has_sync; // Pre-sync beats are dropped here
  assign wr_data  = s_data;
  assign wr_id    = id;
  assign wr_last  = last;
  assign response_id = id;

  // Last flags are precomputed one beat ahead
  assign last = eot ? last_eot : last_non_eot;

  // Ready on the final beat so the next request follows with no gap
  assign last_load = wr_valid & last_eot & eot;
  assign req_ready = last_load | ~active;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      active <= 1'b0;
    end else if (req_valid & req_ready) begin
      active <= 1'b1;
    end else if (last_load) begin
      active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      needs_sync <= 1'b0;
    end else if (req_valid & req_ready) begin
      needs_sync <= req_sync_transfer_start;
    end else if (wr_valid) begin
      needs_sync <= 1'b0; // First marked beat seen
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      beat_counter           <= '0;
      beat_counter_minus_one <= '0;
      last_eot               <= 1'b0;
      last_non_eot           <= 1'b0;
    end else if (req_ready) begin
      beat_counter           <= 'h1;
      beat_counter_minus_one <= '0;
      last_eot               <= req_last_burst_length == '0;
      last_non_eot           <= 1'b0;
    end else if (wr_valid) begin
      beat_counter           <= beat_counter + 1'b1; // Wraps at each full burst
      beat_counter_minus_one <= beat_counter;
      last_eot               <= beat_counter == last_burst_length;
      last_non_eot           <= beat_counter == '1;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready) begin
      last_burst_length <= req_last_burst_length;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bl_valid <= 1'b0;
    end else begin
      bl_valid <= wr_valid & last;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid & last) begin
      measured_last_burst_length <= beat_counter_minus_one;
    end
  end

  assign next_id = (wr_valid & last) ? dma_ctrl_pkg::id_next(id) : id;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      id            <= '0;
      pending_burst <= 1'b0;
    end else begin
      id            <= next_id;
      pending_burst <= next_id != request_id; // Granted slot waiting to be filled
    end
  end

endmodule

/* rtl/dma_burst_buffer.sv */
`timescale 1ns/1ps

module dma_burst_buffer (
  input  logic                                          clk,
  input  logic                                          resetn,
  input  logic                                          wr_valid,
  input  logic [dma_cfg_pkg::DATA_WIDTH-1:0]            wr_data,
  input  logic [dma_cfg_pkg::ID_WIDTH-1:0]              wr_id,
  input  logic                                          wr_last,
  input  logic                                          bl_valid,
  input  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] measured_last_burst_length,
  output logic [dma_cfg_pkg::ID_WIDTH-1:0]              dest_id,
  output logic                                          m_valid,
  input  logic                                          m_ready,
  output logic [dma_cfg_pkg::DATA_WIDTH-1:0]            m_data,
  output logic                                          m_last
);

  logic [dma_cfg_pkg::DATA_WIDTH-1:0]
    mem [dma_cfg_pkg::NUM_SLOTS * 2**dma_cfg_pkg::BEATS_PER_BURST_WIDTH];
  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] slot_len [dma_cfg_pkg::NUM_SLOTS];
  logic [dma_cfg_pkg::NUM_SLOTS-1:0] slot_full;
  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] wr_idx;
  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] rd_idx;
  logic [dma_cfg_pkg::ID_WIDTH-2:0] close_slot;
  logic [dma_cfg_pkg::ID_WIDTH-2:0] rd_slot;
  logic [dma_cfg_pkg::ID_WIDTH-1:0] rd_id;
  logic rd_last;
  logic fetch;

  assign rd_slot = dma_ctrl_pkg::id_slot(rd_id);
  assign rd_last = rd_idx == slot_len[rd_slot];
  assign fetch   = slot_full[rd_slot] & (~m_valid | m_ready);

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[{dma_ctrl_pkg::id_slot(wr_id), wr_idx}] <= wr_data;
    end
    if (wr_valid & wr_last) begin
      close_slot <= dma_ctrl_pkg::id_slot(wr_id); // Length arrives next cycle
    end
    if (bl_valid) begin
      slot_len[close_slot] <= measured_last_burst_length;
    end
    if (fetch) begin
      m_data <= mem[{rd_slot, rd_idx}];
      m_last <= rd_last;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_idx    <= '0;
      slot_full <= '0;
    end else begin
      if (wr_valid) begin
        wr_idx <= wr_last ? '0 : wr_idx + 1'b1;
      end
      if (fetch & rd_last) begin
        slot_full[rd_slot] <= 1'b0;
      end
      if (bl_valid) begin
        slot_full[close_slot] <= 1'b1;
      end
    end
  end

  // Read pointer runs one beat ahead of dest_id
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rd_id   <= '0;
      rd_idx  <= '0;
      dest_id <= '0;
      m_valid <= 1'b0;
    end else begin
      if (fetch) begin
        m_valid <= 1'b1;
        if (rd_last) begin
          rd_idx <= '0;
          rd_id  <= dma_ctrl_pkg::id_next(rd_id);
        end else begin
          rd_idx <= rd_idx + 1'b1;
        end
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
      if (m_valid & m_ready & m_last) begin
        dest_id <= dma_ctrl_pkg::id_next(dest_id); // Slot free for a new grant
      end
    end
  end

endmodule

/* rtl/dma_subsystem.sv */
`timescale 1ns/1ps

module dma_subsystem (
  input  logic                                clk,
  input  logic                                resetn,
  input  logic                                xfer_start,
  input  logic [dma_cfg_pkg::LEN_WIDTH-1:0]   xfer_beats,
  input  logic                                xfer_sync,
  output logic                                xfer_busy,
  output logic                                xfer_done,
  input  logic                                s_valid,
  output logic                                s_ready,
  input  logic [dma_cfg_pkg::DATA_WIDTH-1:0]  s_data,
  input  logic                                s_sync,
  output logic                                m_valid,
  input  logic                                m_ready,
  output logic [dma_cfg_pkg::DATA_WIDTH-1:0]  m_data,
  output logic                                m_last
);

  logic req_valid;
  logic req_ready;
  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] req_last_burst_length;
  logic req_sync_transfer_start;
  logic [dma_cfg_pkg::ID_WIDTH-1:0] request_id;
  logic [dma_cfg_pkg::ID_WIDTH-1:0] response_id;
  logic [dma_cfg_pkg::ID_WIDTH-1:0] dest_id;
  logic eot;
  logic wr_valid;
  logic [dma_cfg_pkg::DATA_WIDTH-1:0] wr_data;
  logic [dma_cfg_pkg::ID_WIDTH-1:0] wr_id;
  logic wr_last;
  logic bl_valid;
  logic [dma_cfg_pkg::BEATS_PER_BURST_WIDTH-1:0] measured_last_burst_length;

  dma_request_ctrl i_request_ctrl (
    .clk                     (clk),
    .resetn                  (resetn),
    .xfer_start              (xfer_start),
    .xfer_beats              (xfer_beats),
    .xfer_sync               (xfer_sync),
    .xfer_busy               (xfer_busy),
    .xfer_done               (xfer_done),
    .req_valid               (req_valid),
    .req_ready               (req_ready),
    .req_last_burst_length   (req_last_burst_length),
    .req_sync_transfer_start (req_sync_transfer_start),
    .request_id              (request_id),
    .response_id             (response_id),
    .eot                     (eot),
    .dest_id                 (dest_id)
  );

  dma_data_mover i_data_mover (
    .clk                        (clk),
    .resetn                     (resetn),
    .request_id                 (request_id),
    .response_id                (response_id),
    .eot                        (eot),
    .req_valid                  (req_valid),
    .req_ready                  (req_ready),
    .req_last_burst_length      (req_last_burst_length),
    .req_sync_transfer_start    (req_sync_transfer_start),
    .s_valid                    (s_valid),
    .s_ready                    (s_ready),
    .s_data                     (s_data),
    .s_sync                     (s_sync),
    .wr_valid                   (wr_valid),
    .wr_data                    (wr_data),
    .wr_id                      (wr_id),
    .wr_last                    (wr_last),
    .bl_valid                   (bl_valid),
    .measured_last_burst_length (measured_last_burst_length)
  );

  dma_burst_buffer i_burst_buffer (
    .clk                        (clk),
    .resetn                     (resetn),
    .wr_valid                   (wr_valid),
    .wr_data                    (wr_data),
    .wr_id                      (wr_id),
    .wr_last                    (wr_last),
    .bl_valid                   (bl_valid),
    .measured_last_burst_length (measured_last_burst_length),
    .dest_id                    (dest_id),
    .m_valid                    (m_valid),
    .m_ready                    (m_ready),
    .m_data                     (m_data),
    .m_last                     (m_last)
  );

endmodule

/* tb/tb_dma_subsystem.sv */
`timescale 1ns/1ps

module tb_dma_subsystem;

  logic clk;
  logic resetn;
  logic xfer_start;
  logic [dma_cfg_pkg::LEN_WIDTH-1:0] xfer_beats;
  logic xfer_sync;
  logic xfer_busy;
  logic xfer_done;
  logic s_valid;
  logic s_ready;
  logic [dma_cfg_pkg::DATA_WIDTH-1:0] s_data;
  logic s_sync;
  logic m_valid;
  logic m_ready;
  logic [dma_cfg_pkg::DATA_WIDTH-1:0] m_data;
  logic m_last;

  int seed = 83;
  int errors = 0;
  int checks = 0;
  int test_no = 0;
  int cycle = 0;
  int done_count = 0;
  int final_hs_cycle = -10;
  int src_taken = 0;
  int stall_run = 0; // Cycles in a row with s_ready low and words waiting
  int src_stall_pct = 0;
  int snk_stall_pct = 0;
  bit hold_sink = 1'b0;
  bit src_take = 1'b0;
  bit prev_hold = 1'b0;
  bit aborted = 1'b0;
  logic [dma_cfg_pkg::DATA_WIDTH-1:0] prev_data;
  logic prev_last;
  logic [dma_cfg_pkg::DATA_WIDTH-1:0] src_data[$];
  bit src_sync[$];
  logic [dma_cfg_pkg::DATA_WIDTH-1:0] exp_data[$];
  bit exp_last[$];

  dma_subsystem i_dma_subsystem (
    .clk        (clk),
    .resetn     (resetn),
    .xfer_start (xfer_start),
    .xfer_beats (xfer_beats),
    .xfer_sync  (xfer_sync),
    .xfer_busy  (xfer_busy),
    .xfer_done  (xfer_done),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_data     (s_data),
    .s_sync     (s_sync),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .m_data     (m_data),
    .m_last     (m_last)
  );

  assert property (@(posedge clk) disable iff (!resetn) xfer_done |=> !xfer_busy)
    else begin
      errors++;
      $display("MISMATCH xfer_busy exp 0 got %h after xfer_done", xfer_busy);
    end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Source, sink and scoreboard; outputs come from flops so they are stable here
  always @(negedge clk) begin
    cycle++;
    if (resetn) begin
      if (src_take) begin
        void'(src_data.pop_front());
        void'(src_sync.pop_front());
        src_taken++;
      end
      if (src_take || !s_valid) begin
        s_valid = 1'b0;
        if (src_data.size() > 0 && rand_below(100) >= src_stall_pct) begin
          s_valid = 1'b1;
          s_data  = src_data[0];
          s_sync  = src_sync[0];
        end
      end
      src_take  = s_valid && s_ready; // Taken at the coming rising edge
      stall_run = (!s_ready && src_data.size() > 0) ? stall_run + 1 : 0;

      if (prev_hold) begin
        checks += 3;
        assert (m_valid) else begin
          errors++;
          $display("m_valid dropped while m_ready was low");
        end
        assert (m_data == prev_data) else begin
          errors++;
          $display("MISMATCH m_data held exp %h got %h", prev_data, m_data);
        end
        assert (m_last == prev_last) else begin
          errors++;
          $display("MISMATCH m_last held exp %h got %h", prev_last, m_last);
        end
      end

      m_ready = !hold_sink && rand_below(100) >= snk_stall_pct;
      if (m_valid && m_ready) begin
        if (exp_data.size() == 0) begin
          errors++;
          $display("output beat %h arrived with no word expected", m_data);
        end else begin
          checks += 2;
          assert (m_data == exp_data[0]) else begin
            errors++;
            $display("MISMATCH m_data exp %h got %h", exp_data[0], m_data);
          end
          assert (m_last == exp_last[0]) else begin
            errors++;
            $display("MISMATCH m_last exp %h got %h", exp_last[0], m_last);
          end
          void'(exp_data.pop_front());
          void'(exp_last.pop_front());
          if (exp_data.size() == 0) begin
            final_hs_cycle = cycle;
          end
        end
      end
      prev_hold = m_valid && !m_ready;
      prev_data = m_data;
      prev_last = m_last;

      if (xfer_done) begin
        done_count++;
        checks++;
        assert (xfer_busy && cycle == final_hs_cycle + 1) else begin
          errors++;
          $display("xfer_done at cycle %0d does not follow the final m_last at cycle %0d",
                   cycle, final_hs_cycle);
        end
      end
    end
  end

  task automatic run_transfer(input string name, input int beats, input bit sync,
                              input int pre, input int src_stall, input int snk_stall,
                              input bit hold, input bit extra_start);
    int i;
    int errs_before;
    bit ok;
    logic [31:0] rnd;
    logic [dma_cfg_pkg::DATA_WIDTH-1:0] word;
    errs_before = errors;
    test_no++;
    @(negedge clk);
    for (i = 0; i < pre; i++) begin
      rnd = rand_word();
      src_data.push_back({8'hee, test_no[7:0], rnd[15:0]}); // Dropped before the marker
      src_sync.push_back(1'b0);
    end
    for (i = 0; i < beats; i++) begin
      rnd  = rand_word();
      word = {test_no[7:0], i[7:0], rnd[15:0]};
      src_data.push_back(word);
      src_sync.push_back(i == 0 ? sync : rnd[16]);
      exp_data.push_back(word);
      exp_last.push_back(i % 16 == 15 || i == beats - 1);
    end
    src_stall_pct  = src_stall;
    snk_stall_pct  = snk_stall;
    hold_sink      = hold;
    done_count     = 0;
    src_taken      = 0;
    final_hs_cycle = -10;
    checks++;
    assert (!xfer_busy) else begin
      errors++;
      $display("MISMATCH xfer_busy exp 0 got %h", xfer_busy);
    end
    xfer_start = 1'b1;
    xfer_beats = beats[dma_cfg_pkg::LEN_WIDTH-1:0] - 1'b1;
    xfer_sync  = sync;
    @(negedge clk);
    xfer_start = 1'b0;
    checks++;
    assert (xfer_busy) else begin
      errors++;
      $display("xfer_busy did not rise after xfer_start");
    end
    if (extra_start) begin
      repeat (3) @(negedge clk);
      xfer_start = 1'b1; // Must be ignored while busy
      xfer_beats = 'h05;
      @(negedge clk);
      xfer_start = 1'b0;
    end
    if (hold) begin
      ok = 1'b0;
      for (i = 0; i < 2000; i++) begin
        @(posedge clk);
        if (stall_run >= 16 && src_taken > 0) begin
          ok = 1'b1;
          break;
        end
      end
      if (!ok) begin
        errors++;
        $display("timeout waiting for s_ready to stall under back-pressure");
      end
      checks++;
      assert (src_taken == dma_cfg_pkg::NUM_SLOTS * 16) else begin
        errors++;
        $display("MISMATCH s_ready beats taken exp %h got %h",
                 dma_cfg_pkg::NUM_SLOTS * 16, src_taken);
      end
      @(negedge clk);
      hold_sink = 1'b0;
    end
    ok = 1'b0;
    for (i = 0; i < 5000; i++) begin
      @(posedge clk);
      if (done_count > 0) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      errors++;
      aborted = 1'b1;
      $display("timeout waiting for xfer_done in test %0d", test_no);
    end else begin
      repeat (10) @(negedge clk);
      checks += 4;
      assert (done_count == 1) else begin
        errors++;
        $display("MISMATCH xfer_done pulses exp %h got %h", 1, done_count);
      end
      assert (!xfer_busy) else begin
        errors++;
        $display("MISMATCH xfer_busy exp 0 got %h", xfer_busy);
      end
      assert (exp_data.size() == 0) else begin
        errors++;
        $display("%0d expected words never reached m_data", exp_data.size());
      end
      assert (src_data.size() == 0) else begin
        errors++;
        $display("%0d source words were never taken", src_data.size());
      end
    end
    $display("test %0d %s: %s", test_no, name, errors == errs_before ? "ok" : "errors found");
  endtask

  initial begin
    resetn     = 1'b0;
    xfer_start = 1'b0;
    xfer_beats = '0;
    xfer_sync  = 1'b0;
    s_valid    = 1'b0;
    s_data     = '0;
    s_sync     = 1'b0;
    m_ready    = 1'b0;
    repeat (10) @(negedge clk);
    resetn = 1'b1;
    checks += 2;
    assert (!xfer_busy && !m_valid) else begin
      errors++;
      $display("MISMATCH xfer_busy/m_valid after reset exp 0/0 got %h/%h", xfer_busy, m_valid);
    end
    run_transfer("single beat", 1, 1'b0, 0, 0, 0, 1'b0, 1'b0);
    if (!aborted) run_transfer("one full burst", 16, 1'b0, 0, 25, 25, 1'b0, 1'b0);
    if (!aborted) run_transfer("burst plus one", 17, 1'b0, 0, 30, 20, 1'b0, 1'b0);
    if (!aborted) run_transfer("hundred beats", 100, 1'b0, 0, 20, 40, 1'b0, 1'b0);
    if (!aborted) run_transfer("sync start", 40, 1'b1, 5, 20, 20, 1'b0, 1'b0);
    if (!aborted) run_transfer("sink held low", 100, 1'b0, 0, 20, 10, 1'b1, 1'b0);
    if (!aborted) run_transfer("start while busy", 20, 1'b0, 0, 10, 10, 1'b0, 1'b1);
    $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
rtl/dma_cfg_pkg.sv
rtl/dma_ctrl_pkg.sv
rtl/dma_request_ctrl.sv
rtl/dma_data_mover.sv
rtl/dma_burst_buffer.sv
rtl/dma_subsystem.sv
tb/tb_dma_subsystem.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_dma_subsystem \
  -f tb.f -o tb_dma_subsystem > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_dma_subsystem > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$SIM_LOG"; then
  exit 1
fi
exit 0
